// ==== verilog.f ====
+incdir+include
design/mem_stage_pkg.sv
design/mem_stage_ctrl.sv
design/addr_store_unit.sv
design/load_aligner.sv
design/mem_stage_top.sv
verif/tb_mem_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 -f verilog.f --top-module tb_mem_stage

./obj_dir/Vtb_mem_stage | tee sim.log

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Test OK" sim.log; then
    exit 1
fi
exit 0

// ==== verif/tb_mem_stage.sv ====
`include "mem_stage_cfg.svh"

module tb_mem_stage;

timeunit 1ns;
timeprecision 1ps;

localparam int N_INSTR      = 84;
localparam int RESET_CYCLES = 16;
localparam int CYCLE_LIMIT  = N_INSTR * 20 + RESET_CYCLES;

logic                     clk           = 1'b0;
logic                     reset         = 1'b1;
logic                     instr_valid_i = 1'b0;
mem_stage_pkg::instr_u    instr_i       = '0;
mem_stage_pkg::word_t     rs1_val_i     = '0;
mem_stage_pkg::word_t     rs2_val_i     = '0;
logic                     hold_i        = 1'b0;
logic                     mem_yumi_i    = 1'b0;
logic                     mem_valid_i   = 1'b0;
mem_stage_pkg::word_t     mem_rdata_i   = '0;
logic                     reservation_i = 1'b0;
logic                     mem_v_o;
logic                     mem_w_o;
mem_stage_pkg::word_t     mem_addr_o;
mem_stage_pkg::word_t     mem_wdata_o;
logic [3:0]               mem_mask_o;
logic                     mem_yumi_o;
logic                     reserve_o;
logic                     wb_v_o;
mem_stage_pkg::reg_addr_t wb_rd_o;
mem_stage_pkg::word_t     wb_data_o;
logic                     stall_o;

// Memory image, 64 words
logic [7:0] mem_img [256];
int         val_errs   = 0;
int         other_errs = 0;
logic [31:0] rng_s = 32'd73665;
logic [31:0] rng_m = 32'd73665 ^ 32'h9E3779B9;
logic [31:0] rng_h = 32'd73665 ^ 32'h7F4A7C15;
logic       fast_mode    = 1'b0;
logic       rand_hold    = 1'b0;
logic       hold_on_resp = 1'b0;

// Instruction on the execute inputs
int                        cur_kind;
mem_stage_pkg::mem_width_e cur_width;
logic                      cur_uns;
logic                      cur_aq;
mem_stage_pkg::reg_addr_t  cur_rd;
mem_stage_pkg::word_t      cur_rs1;
mem_stage_pkg::word_t      cur_rs2;
mem_stage_pkg::word_t      cur_addr;

// Mirror of the execute stage
logic                      exe_v = 1'b0;
int                        exe_kind;
mem_stage_pkg::mem_width_e exe_width;
logic                      exe_uns;
logic                      exe_aq;
mem_stage_pkg::reg_addr_t  exe_rd;
mem_stage_pkg::word_t      exe_rs1 = '0;
mem_stage_pkg::word_t      exe_rs2 = '0;
mem_stage_pkg::word_t      exe_addr;
time                       exe_t;

// Mirror of the memory stage
logic                      mem_ld    = 1'b0;
logic                      mem_got   = 1'b0;
logic                      stall_exp = 1'b0;

// Memory model timing, in monitor cycles
int                   mcyc       = 0;
int                   yumi_ready = 0;
int                   resp_at    = 0;
logic                 resp_pend  = 1'b0;
mem_stage_pkg::word_t resp_word;
int                   hold_cnt   = 0;
logic                 idle_checked = 1'b0;
int                   cycles     = 0;

// Expected writebacks in issue order
mem_stage_pkg::word_t     q_data [$];
mem_stage_pkg::reg_addr_t q_rd [$];
time                      q_t [$];
logic                     q_fast [$];

mem_stage_top i_mem_stage_top
(
    .clk           (clk),
    .reset         (reset),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rs1_val_i     (rs1_val_i),
    .rs2_val_i     (rs2_val_i),
    .hold_i        (hold_i),
    .mem_v_o       (mem_v_o),
    .mem_w_o       (mem_w_o),
    .mem_addr_o    (mem_addr_o),
    .mem_wdata_o   (mem_wdata_o),
    .mem_mask_o    (mem_mask_o),
    .mem_yumi_i    (mem_yumi_i),
    .mem_valid_i   (mem_valid_i),
    .mem_rdata_i   (mem_rdata_i),
    .mem_yumi_o    (mem_yumi_o),
    .reservation_i (reservation_i),
    .reserve_o     (reserve_o),
    .wb_v_o        (wb_v_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o),
    .stall_o       (stall_o)
);

always #4 clk = ~clk;

////////////////////
// Helpers

function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic mem_stage_pkg::word_t read_word(input logic [7:0] a);
    return {mem_img[{a[7:2], 2'd3}], mem_img[{a[7:2], 2'd2}],
            mem_img[{a[7:2], 2'd1}], mem_img[{a[7:2], 2'd0}]};
endfunction

// Expected load value from the image, width and unsigned flag
function automatic mem_stage_pkg::word_t ref_load(input logic [7:0] a,
                                                  input mem_stage_pkg::mem_width_e w,
                                                  input logic uns);
    logic [7:0]           b;
    logic [15:0]          h;
    mem_stage_pkg::word_t r;
    b = mem_img[a];
    h = {mem_img[{a[7:1], 1'b1}], mem_img[{a[7:1], 1'b0}]};
    case (w)
        mem_stage_pkg::MEM_BYTE: r = uns ? {24'h0, b} : {{24{b[7]}}, b};
        mem_stage_pkg::MEM_HALF: r = uns ? {16'h0, h} : {{16{h[15]}}, h};
        default:                 r = read_word(a);
    endcase
    return r;
endfunction

task automatic check_word(input string name, input mem_stage_pkg::word_t got,
                          input mem_stage_pkg::word_t exp);
    if (got !== exp)
    begin
        val_errs++;
        $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
endtask

task automatic check_rd(input string name, input mem_stage_pkg::reg_addr_t got,
                        input mem_stage_pkg::reg_addr_t exp);
    if (got !== exp)
    begin
        val_errs++;
        $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
endtask

task automatic check_mask(input string name, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp)
    begin
        val_errs++;
        $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
        val_errs++;
        $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
endtask

// Present one op and wait until execute takes it
task automatic issue(input int kind, input mem_stage_pkg::mem_width_e w, input logic uns,
                     input logic aq, input logic [1:0] lane);
    logic [31:0]              r;
    logic [31:0]              iw;
    logic [11:0]              imm;
    mem_stage_pkg::word_t     sext;
    mem_stage_pkg::word_t     target;
    mem_stage_pkg::reg_addr_t rd;
    rng_s = xorshift(rng_s);
    r     = rng_s;
    rd    = r[4:0];
    imm   = {{4{r[12]}}, r[12:5]};
    rng_s = xorshift(rng_s);
    target = (rng_s & 32'hFFFF_FF00) | {24'h0, r[20:15], lane};
    rng_s = xorshift(rng_s);
    cur_rs2 = rng_s;
    case (kind)
        0:       iw = {imm, 5'd1, uns, w, rd, `OP_LOAD};
        1:       iw = {imm[11:5], 5'd2, 5'd1, 1'b0, w, imm[4:0], `OP_STORE};
        default: iw = {`FUNCT5_LR, aq, 1'b0, 5'd0, 5'd1, 3'b010, rd, `OP_AMO};
    endcase
    // S-immediate for stores, upper 12 bits otherwise
    if (kind == 1)
        sext = {{20{imm[11]}}, imm};
    else
        sext = {{20{iw[31]}}, iw[31:20]};
    cur_kind  = kind;
    cur_width = (kind == 2) ? mem_stage_pkg::MEM_WORD : w;
    cur_uns   = (kind == 0) & uns;
    cur_aq    = aq;
    cur_rd    = rd;
    cur_addr  = target;
    cur_rs1   = target - sext;
    instr_i   = iw;
    instr_valid_i = 1'b1;
    do
        @(posedge clk);
    while (stall_o);
    @(negedge clk);
    instr_valid_i = 1'b0;
endtask

task automatic wait_idle();
    do
        @(negedge clk);
    while (q_data.size() != 0 || exe_v || resp_pend);
    repeat (3) @(negedge clk);
endtask

////////////////////
// Memory model and monitor

// Request accepted, model the bus side
task automatic accept_request();
    logic [1:0]           lane;
    mem_stage_pkg::word_t wd;
    logic [3:0]           mk;
    lane = exe_addr[1:0];
    check_word("mem_addr_o", mem_addr_o, exe_addr);
    check_bit("mem_w_o", mem_w_o, exe_kind == 1);
    rng_m = xorshift(rng_m);
    yumi_ready = fast_mode ? mcyc : mcyc + int'(rng_m[1:0]);
    if (exe_kind == 1)
    begin
        case (exe_width)
            mem_stage_pkg::MEM_BYTE:
            begin
                wd = mem_stage_pkg::word_t'(exe_rs2[7:0]) << (8 * lane);
                mk = 4'b0001 << lane;
            end
            mem_stage_pkg::MEM_HALF:
            begin
                wd = mem_stage_pkg::word_t'(exe_rs2[15:0]) << (8 * lane);
                mk = 4'b0011 << lane;
            end
            default:
            begin
                wd = exe_rs2;
                mk = 4'b1111;
            end
        endcase
        check_word("mem_wdata_o", mem_wdata_o, wd);
        check_mask("mem_mask_o", mem_mask_o, mk);
        for (int i = 0; i < 4; i++)
            if (mk[i])
                mem_img[{exe_addr[7:2], 2'(i)}] = wd[8*i +: 8];
    end
    else
    begin
        q_data.push_back(ref_load(exe_addr[7:0], exe_width, exe_uns));
        q_rd.push_back(exe_rd);
        q_t.push_back(exe_t);
        q_fast.push_back(fast_mode);
        resp_word = read_word(exe_addr[7:0]);
        resp_pend = 1'b1;
        // Response 1 to 4 cycles later
        resp_at   = fast_mode ? mcyc : mcyc + int'(rng_m[3:2]);
    end
endtask

always @(posedge clk)
begin
    if (reset)
    begin
        exe_v     = 1'b0;
        mem_ld    = 1'b0;
        mem_got   = 1'b0;
        resp_pend = 1'b0;
        mcyc      = 0;
        yumi_ready = 0;
    end
    else
    begin
        mcyc++;
        // Idle outputs right after reset
        if (!idle_checked)
        begin
            check_bit("mem_v_o", mem_v_o, 1'b0);
            check_bit("mem_yumi_o", mem_yumi_o, 1'b0);
            check_bit("reserve_o", reserve_o, 1'b0);
            check_bit("wb_v_o", wb_v_o, 1'b0);
            check_bit("stall_o", stall_o, 1'b0);
            idle_checked = 1'b1;
        end
        // Stall rule applied to the mirrored stages
        stall_exp = hold_i
                  || (exe_v && !mem_yumi_i)
                  || (mem_ld && !mem_valid_i && !mem_got)
                  || (exe_v && exe_kind == 2 && exe_aq && reservation_i);
        check_bit("stall_o", stall_o, stall_exp);
        check_bit("mem_yumi_o", mem_yumi_o, mem_ld && mem_valid_i);
        check_bit("reserve_o", reserve_o, exe_v && exe_kind == 2 && !exe_aq);
        if (mem_valid_i)
            resp_pend = 1'b0;
        if (exe_v && exe_kind == 2 && exe_aq && reservation_i && mem_v_o)
        begin
            other_errs++;
            $display("Request raised while LR.W waits on a live reservation");
        end
        if (mem_v_o && !exe_v)
        begin
            other_errs++;
            $display("Request raised with no memory op in execute");
        end
        if (mem_v_o && mem_yumi_i && exe_v)
            accept_request();
        // Both stages move whenever there is no stall
        if (!stall_exp)
        begin
            mem_ld    = exe_v && exe_kind != 1;
            mem_got   = 1'b0;
            exe_v     = instr_valid_i;
            exe_kind  = cur_kind;
            exe_width = cur_width;
            exe_uns   = cur_uns;
            exe_aq    = cur_aq;
            exe_rd    = cur_rd;
            exe_rs1   = cur_rs1;
            exe_rs2   = cur_rs2;
            exe_addr  = cur_addr;
            exe_t     = $time;
        end
        // Data that lands during a stall stays with the load
        else if (mem_ld && mem_valid_i)
            mem_got = 1'b1;
    end
end

// Bus inputs and hold change on the falling edge
always @(negedge clk)
begin
    rs1_val_i = exe_rs1;
    rs2_val_i = exe_rs2;
    if (reset)
    begin
        mem_yumi_i  = 1'b0;
        mem_valid_i = 1'b0;
        hold_i      = 1'b0;
        hold_cnt    = 0;
    end
    else
    begin
        mem_yumi_i  = (mcyc >= yumi_ready);
        mem_valid_i = resp_pend && (mcyc >= resp_at);
        if (mem_valid_i)
        begin
            mem_rdata_i = resp_word;
            if (hold_on_resp)
                hold_cnt = 3;
        end
        // Bus data is junk outside the valid cycle
        else
            mem_rdata_i = ~resp_word;
        rng_h  = xorshift(rng_h);
        hold_i = (hold_cnt > 0) || (rand_hold && rng_h[2:0] == 3'd0);
        if (hold_cnt > 0)
            hold_cnt--;
    end
end

////////////////////
// Writeback compare

always @(posedge clk)
begin
    if (!reset && wb_v_o)
    begin
        if (q_data.size() == 0)
        begin
            other_errs++;
            $display("Writeback seen with no load outstanding");
        end
        else
        begin
            check_rd("wb_rd_o", wb_rd_o, q_rd[0]);
            check_word("wb_data_o", wb_data_o, q_data[0]);
            // Rises 2 edges after acceptance, seen here one edge later
            if (q_fast[0] && ($time - q_t[0] != 64'd24))
            begin
                other_errs++;
                $display("Load writeback came %0t after acceptance with no stall", $time - q_t[0]);
            end
            void'(q_data.pop_front());
            void'(q_rd.pop_front());
            void'(q_t.pop_front());
            void'(q_fast.pop_front());
        end
    end
end

always @(posedge clk)
begin
    cycles++;
    if (cycles >= CYCLE_LIMIT)
    begin
        $display("Timeout after %0d cycles with the test still running", cycles);
        $display("Errors: value %0d, other %0d", val_errs, other_errs + 1);
        $display("Test FAILED");
        $finish;
    end
end

////////////////////
// Stimulus

initial
begin
    logic [31:0]               r;
    int                        kind;
    mem_stage_pkg::mem_width_e w;
    logic [1:0]                lane;
    for (int a = 0; a < 256; a++)
        mem_img[a] = 8'(a * 29) ^ 8'h5A;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Every width and lane, no back-pressure
    fast_mode = 1'b1;
    for (int l = 0; l < 4; l++)
    begin
        issue(1, mem_stage_pkg::MEM_BYTE, 1'b0, 1'b0, 2'(l));
        issue(0, mem_stage_pkg::MEM_BYTE, 1'b0, 1'b0, 2'(l));
        issue(0, mem_stage_pkg::MEM_BYTE, 1'b1, 1'b0, 2'(l));
    end
    for (int l = 0; l < 4; l += 2)
    begin
        issue(1, mem_stage_pkg::MEM_HALF, 1'b0, 1'b0, 2'(l));
        issue(0, mem_stage_pkg::MEM_HALF, 1'b0, 1'b0, 2'(l));
        issue(0, mem_stage_pkg::MEM_HALF, 1'b1, 1'b0, 2'(l));
    end
    issue(1, mem_stage_pkg::MEM_WORD, 1'b0, 1'b0, 2'd0);
    issue(0, mem_stage_pkg::MEM_WORD, 1'b0, 1'b0, 2'd0);
    wait_idle();
    fast_mode = 1'b0;

    // Responses that land under hold
    hold_on_resp = 1'b1;
    issue(0, mem_stage_pkg::MEM_WORD, 1'b0, 1'b0, 2'd0);
    issue(0, mem_stage_pkg::MEM_HALF, 1'b1, 1'b0, 2'd2);
    wait_idle();
    hold_on_resp = 1'b0;

    // LR.W requesting, then LR.W waiting on a live reservation
    issue(2, mem_stage_pkg::MEM_WORD, 1'b0, 1'b0, 2'd0);
    reservation_i = 1'b1;
    issue(2, mem_stage_pkg::MEM_WORD, 1'b0, 1'b1, 2'd0);
    repeat (5) @(negedge clk);
    reservation_i = 1'b0;
    wait_idle();

    // Random mix with random delays and hold pulses
    rand_hold = 1'b1;
    for (int n = 0; n < 60; n++)
    begin
        rng_s = xorshift(rng_s);
        r     = rng_s;
        kind  = int'(r % 32'd5);
        case (r[4:3])
            2'd0:    w = mem_stage_pkg::MEM_BYTE;
            2'd1:    w = mem_stage_pkg::MEM_HALF;
            default: w = mem_stage_pkg::MEM_WORD;
        endcase
        if (w == mem_stage_pkg::MEM_BYTE)
            lane = r[6:5];
        else if (w == mem_stage_pkg::MEM_HALF)
            lane = {r[6], 1'b0};
        else
            lane = 2'd0;
        if (kind < 2)
            issue(0, w, r[7] & (w != mem_stage_pkg::MEM_WORD), 1'b0, lane);
        else if (kind < 4)
            issue(1, w, 1'b0, 1'b0, lane);
        else
            issue(2, mem_stage_pkg::MEM_WORD, 1'b0, 1'b0, 2'd0);
    end
    rand_hold = 1'b0;
    wait_idle();

    $display("Errors: value %0d, other %0d", val_errs, other_errs);
    if (val_errs + other_errs == 0)
        $display("Test OK");
    else
        $display("Test FAILED");
    $finish;
end

endmodule

// ==== design/mem_stage_top.sv ====
module mem_stage_top
(
    input  logic                     clk,
    input  logic                     reset,
    // Execute side
    input  logic                     instr_valid_i,
    input  mem_stage_pkg::instr_u    instr_i,
    input  mem_stage_pkg::word_t     rs1_val_i,
    input  mem_stage_pkg::word_t     rs2_val_i,
    input  logic                     hold_i,
    // Memory request
    output logic                     mem_v_o,
    output logic                     mem_w_o,
    output mem_stage_pkg::word_t     mem_addr_o,
    output mem_stage_pkg::word_t     mem_wdata_o,
    output logic [3:0]               mem_mask_o,
    input  logic                     mem_yumi_i,
    // Memory response
    input  logic                     mem_valid_i,
    input  mem_stage_pkg::word_t     mem_rdata_i,
    output logic                     mem_yumi_o,
    // Reservation
    input  logic                     reservation_i,
    output logic                     reserve_o,
    // Writeback and stall
    output logic                     wb_v_o,
    output mem_stage_pkg::reg_addr_t wb_rd_o,
    output mem_stage_pkg::word_t     wb_data_o,
    output logic                     stall_o
);

// Execute stage view
mem_stage_pkg::instr_u     exe_instr;
mem_stage_pkg::mem_width_e exe_width;
logic [1:0]                addr_lane;

// Memory stage view
mem_stage_pkg::mem_width_e mem_width;
logic                      mem_unsigned;
logic [1:0]                mem_lane;
logic                      mem_load;
mem_stage_pkg::reg_addr_t  mem_rd;

// Pipeline control
logic                      advance;
logic                      buffer_load;

////////////////////
// Stage control
mem_stage_ctrl i_mem_stage_ctrl
(
    .clk            (clk),
    .reset          (reset),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .hold_i         (hold_i),
    .mem_yumi_i     (mem_yumi_i),
    .mem_valid_i    (mem_valid_i),
    .reservation_i  (reservation_i),
    .addr_lane_i    (addr_lane),
    .stall_o        (stall_o),
    .mem_v_o        (mem_v_o),
    .mem_w_o        (mem_w_o),
    .mem_yumi_o     (mem_yumi_o),
    .reserve_o      (reserve_o),
    .exe_instr_o    (exe_instr),
    .exe_width_o    (exe_width),
    .mem_width_o    (mem_width),
    .mem_unsigned_o (mem_unsigned),
    .mem_lane_o     (mem_lane),
    .mem_load_o     (mem_load),
    .mem_rd_o       (mem_rd),
    .advance_o      (advance),
    .buffer_load_o  (buffer_load)
);

// Address and store data in execute
addr_store_unit i_addr_store_unit
(
    .exe_instr_i (exe_instr),
    .exe_width_i (exe_width),
    .rs1_val_i   (rs1_val_i),
    .rs2_val_i   (rs2_val_i),
    .addr_o      (mem_addr_o),
    .addr_lane_o (addr_lane),
    .wdata_o     (mem_wdata_o),
    .mask_o      (mem_mask_o)
);

// Load data shaping and writeback
load_aligner i_load_aligner
(
    .clk           (clk),
    .reset         (reset),
    .rdata_i       (mem_rdata_i),
    .valid_i       (mem_valid_i),
    .buffer_load_i (buffer_load),
    .advance_i     (advance),
    .load_i        (mem_load),
    .width_i       (mem_width),
    .unsigned_i    (mem_unsigned),
    .lane_i        (mem_lane),
    .rd_i          (mem_rd),
    .wb_v_o        (wb_v_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o)
);

endmodule

// ==== design/load_aligner.sv ====
`include "mem_stage_cfg.svh"

module load_aligner
(
    input  logic                      clk,
    input  logic                      reset,
    input  mem_stage_pkg::word_t      rdata_i,
    input  logic                      valid_i,
    input  logic                      buffer_load_i,
    input  logic                      advance_i,
    input  logic                      load_i,
    input  mem_stage_pkg::mem_width_e width_i,
    input  logic                      unsigned_i,
    input  logic [1:0]                lane_i,
    input  mem_stage_pkg::reg_addr_t  rd_i,
    output logic                      wb_v_o,
    output mem_stage_pkg::reg_addr_t  wb_rd_o,
    output mem_stage_pkg::word_t      wb_data_o
);

mem_stage_pkg::word_t     buf_r;
mem_stage_pkg::word_t     loaded;
logic [7:0]               ld_byte;
logic [15:0]              ld_half;
mem_stage_pkg::word_t     result;
logic                     wb_v_r;
mem_stage_pkg::reg_addr_t wb_rd_r;
mem_stage_pkg::word_t     wb_data_r;

////////////////////
// Response buffer

// Filled while frozen, emptied when the stage moves on
always_ff @(posedge clk)
begin
    if (advance_i)
        buf_r <= '0;
    else if (buffer_load_i)
        buf_r <= rdata_i;
end

// Memory answers once per load, so live data wins over the buffer
assign loaded = valid_i ? rdata_i : buf_r;

// Byte picked by lane
always_comb
begin
    case (lane_i)
        2'b00:   ld_byte = loaded[7:0];
        2'b01:   ld_byte = loaded[15:8];
        2'b10:   ld_byte = loaded[23:16];
        default: ld_byte = loaded[31:24];
    endcase
end

// Halfword: any nonzero lane means the upper half
assign ld_half = (|lane_i) ? loaded[31:16] : loaded[15:0];

// Sign or zero extend
always_comb
begin
    case (width_i)
        mem_stage_pkg::MEM_BYTE:
            result = unsigned_i ? {{(`XLEN-8){1'b0}}, ld_byte}
                                : {{(`XLEN-8){ld_byte[7]}}, ld_byte};
        mem_stage_pkg::MEM_HALF:
            result = unsigned_i ? {{(`XLEN-16){1'b0}}, ld_half}
                                : {{(`XLEN-16){ld_half[15]}}, ld_half};
        default:
            result = loaded;
    endcase
end

////////////////////
// Writeback register

// Valid is a single pulse per completed load
always_ff @(posedge clk)
begin
    if (reset)
        wb_v_r <= 1'b0;
    else
        wb_v_r <= advance_i & load_i;
end

always_ff @(posedge clk)
begin
    if (advance_i)
    begin
        wb_rd_r   <= rd_i;
        wb_data_r <= result;
    end
end

assign wb_v_o    = wb_v_r;
assign wb_rd_o   = wb_rd_r;
assign wb_data_o = wb_data_r;

endmodule

// ==== design/addr_store_unit.sv ====
`include "mem_stage_cfg.svh"

module addr_store_unit
(
    input  mem_stage_pkg::instr_u     exe_instr_i,
    input  mem_stage_pkg::mem_width_e exe_width_i,
    input  mem_stage_pkg::word_t      rs1_val_i,
    input  mem_stage_pkg::word_t      rs2_val_i,
    output mem_stage_pkg::word_t      addr_o,
    output logic [1:0]                addr_lane_o,
    output mem_stage_pkg::word_t      wdata_o,
    output logic [3:0]                mask_o
);

logic [11:0]          imm;
logic                 is_store;
logic [4:0]           shamt;
mem_stage_pkg::word_t addr;

// Stores carry a split immediate, everything else is I-type
assign is_store = (exe_instr_i.st.opcode == `OP_STORE);
assign imm      = is_store ? {exe_instr_i.st.imm_hi7, exe_instr_i.st.imm_lo5}
                           : exe_instr_i.ld.imm12;

assign addr        = rs1_val_i + {{(`XLEN-12){imm[11]}}, imm};
assign addr_o      = addr;
assign addr_lane_o = addr[1:0];

// Byte offset of the lane as a bit shift
assign shamt = {addr[1:0], 3'b000};

////////////////////
// Store lane placement
always_comb
begin
    case (exe_width_i)
        mem_stage_pkg::MEM_BYTE:
        begin
            wdata_o = mem_stage_pkg::word_t'(rs2_val_i[7:0]) << shamt;
            mask_o  = 4'b0001 << addr[1:0];
        end
        mem_stage_pkg::MEM_HALF:
        begin
            wdata_o = mem_stage_pkg::word_t'(rs2_val_i[15:0]) << shamt;
            mask_o  = 4'b0011 << addr[1:0];
        end
        default:
        begin
            // Full word, no shift
            wdata_o = rs2_val_i;
            mask_o  = 4'b1111;
        end
    endcase
end

endmodule

// ==== design/mem_stage_ctrl.sv ====
`include "mem_stage_cfg.svh"

module mem_stage_ctrl
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      instr_valid_i,
    input  mem_stage_pkg::instr_u     instr_i,
    input  logic                      hold_i,
    input  logic                      mem_yumi_i,
    input  logic                      mem_valid_i,
    input  logic                      reservation_i,
    input  logic [1:0]                addr_lane_i,
    output logic                      stall_o,
    output logic                      mem_v_o,
    output logic                      mem_w_o,
    output logic                      mem_yumi_o,
    output logic                      reserve_o,
    output mem_stage_pkg::instr_u     exe_instr_o,
    output mem_stage_pkg::mem_width_e exe_width_o,
    output mem_stage_pkg::mem_width_e mem_width_o,
    output logic                      mem_unsigned_o,
    output logic [1:0]                mem_lane_o,
    output logic                      mem_load_o,
    output mem_stage_pkg::reg_addr_t  mem_rd_o,
    output logic                      advance_o,
    output logic                      buffer_load_o
);

// Decode of the incoming word
logic                      in_load;
logic                      in_store;
logic                      in_lr;
logic                      in_mem;
mem_stage_pkg::mem_width_e in_width;

// Execute stage
logic                      exe_v_r;
logic                      exe_store_r;
logic                      exe_lr_r;
logic                      exe_unsigned_r;
mem_stage_pkg::instr_u     exe_instr_r;
mem_stage_pkg::mem_width_e exe_width_r;

// Memory stage, only loads matter here
logic                      mem_load_r;
logic                      mem_unsigned_r;
mem_stage_pkg::mem_width_e mem_width_r;
logic [1:0]                mem_lane_r;
mem_stage_pkg::reg_addr_t  mem_rd_r;
logic                      buf_v_r;

logic                      lr_wait;
logic                      mem_wait;
logic                      stall;

////////////////////
// Opcode decode

// Opcode field sits at the same place in both views
assign in_load  = (instr_i.ld.opcode == `OP_LOAD);
assign in_store = (instr_i.ld.opcode == `OP_STORE);
// funct5 is the top of the I-type immediate
assign in_lr    = (instr_i.ld.opcode == `OP_AMO) & (instr_i.ld.imm12[11:7] == `FUNCT5_LR);
assign in_mem   = in_load | in_store | in_lr;

always_comb
begin
    // LR.W is always a full word
    if (in_lr)
        in_width = mem_stage_pkg::MEM_WORD;
    else
    begin
        case (instr_i.ld.funct3[1:0])
            2'b00:   in_width = mem_stage_pkg::MEM_BYTE;
            2'b01:   in_width = mem_stage_pkg::MEM_HALF;
            default: in_width = mem_stage_pkg::MEM_WORD;
        endcase
    end
end

////////////////////
// Stall and strobes

// LR.W with aq waits while another reservation is live
assign lr_wait  = exe_v_r & exe_lr_r & exe_instr_r[`AQ_BIT] & reservation_i;

// Load in memory stage with no data from the bus or the buffer
assign mem_wait = mem_load_r & ~mem_valid_i & ~buf_v_r;

assign stall = hold_i
             | (exe_v_r & ~mem_yumi_i)
             | mem_wait
             | lr_wait;

// Request only when the memory stage can take it, so yumi means one accept
assign mem_v_o    = exe_v_r & ~hold_i & ~lr_wait & ~mem_wait;
assign mem_w_o    = exe_v_r & exe_store_r;
// Returned data is always taken, even under hold
assign mem_yumi_o = mem_load_r & mem_valid_i;
assign reserve_o  = exe_v_r & exe_lr_r & ~exe_instr_r[`AQ_BIT];

// Data that arrives while the stages are frozen goes to the buffer
assign buffer_load_o = mem_load_r & mem_valid_i & stall;
assign advance_o     = ~stall;
assign stall_o       = stall;

////////////////////
// Stage registers

always_ff @(posedge clk)
begin
    if (reset)
    begin
        exe_v_r    <= 1'b0;
        mem_load_r <= 1'b0;
        buf_v_r    <= 1'b0;
    end
    else
    begin
        if (~stall)
        begin
            // Non-memory opcodes never enter
            exe_v_r    <= instr_valid_i & in_mem;
            // Stores drop out here, loads and LR.W go on to writeback
            mem_load_r <= exe_v_r & ~exe_store_r;
            buf_v_r    <= 1'b0;
        end
        else if (buffer_load_o)
            buf_v_r <= 1'b1;
    end
end

// Payload follows the valid bits
always_ff @(posedge clk)
begin
    if (~stall)
    begin
        exe_instr_r    <= instr_i;
        exe_store_r    <= in_store;
        exe_lr_r       <= in_lr;
        exe_width_r    <= in_width;
        exe_unsigned_r <= in_load & instr_i.ld.funct3[2];
        mem_width_r    <= exe_width_r;
        mem_unsigned_r <= exe_unsigned_r;
        mem_lane_r     <= addr_lane_i;
        mem_rd_r       <= exe_instr_r.ld.rd;
    end
end

assign exe_instr_o    = exe_instr_r;
assign exe_width_o    = exe_width_r;
assign mem_width_o    = mem_width_r;
assign mem_unsigned_o = mem_unsigned_r;
assign mem_lane_o     = mem_lane_r;
assign mem_load_o     = mem_load_r;
assign mem_rd_o       = mem_rd_r;

endmodule

// ==== design/mem_stage_pkg.sv ====
`include "mem_stage_cfg.svh"

package mem_stage_pkg;

    // Data and address word
    typedef logic [`XLEN-1:0] word_t;

    // Register index
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Access size, taken from funct3[1:0]
    typedef enum logic [1:0]
    {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_width_e;

    ////////////////////
    // Instruction views

    // I-type, used by loads and LR.W
    typedef struct packed
    {
        logic [11:0] imm12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } load_fmt_s;

    // S-type, immediate split around rs2
    typedef struct packed
    {
        logic [6:0]  imm_hi7;
        reg_addr_t   rs2;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo5;
        logic [6:0]  opcode;
    } store_fmt_s;

    // Same 32-bit word, read as I-type or S-type by the op kind
    typedef union packed
    {
        load_fmt_s  ld;
        store_fmt_s st;
    } instr_u;

endpackage

// ==== include/mem_stage_cfg.svh ====
`ifndef MEM_STAGE_CFG_SVH
`define MEM_STAGE_CFG_SVH

////////////////////
// Datapath widths
`define XLEN 32
`define REG_ADDR_W 5

////////////////////
// RV32 major opcodes handled by the memory path
`define OP_LOAD 7'b0000011
`define OP_STORE 7'b0100011
`define OP_AMO 7'b0101111

// funct5 of LR.W inside the AMO opcode
`define FUNCT5_LR 5'b00010

// Set on LR.W means wait for the reservation, clear means request one
`define AQ_BIT 26

`endif
